//--- source/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// side of the square convolution window
`define CONV_KERNEL_SIZE 3

// pixels in one row of the input feature map
`define CONV_IFM_SIZE 8

// input channels folded into one filter
`define CONV_IFM_DEPTH 2

// conv units sharing one window
`define CONV_NUM_UNITS 3

// filters (and biases) handled by each unit
`define CONV_BIAS_DEPTH 4

`endif

//--- source/conv_pkg.sv
`include "conv_settings.svh"

package conv_pkg;

	// taps in one KxK window
	localparam int KERNEL_TAPS = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;

	// weight words per unit, one window per input channel
	localparam int WM_DEPTH = KERNEL_TAPS * `CONV_IFM_DEPTH;

	localparam int WM_ADDR_W = (WM_DEPTH > 1) ? $clog2(WM_DEPTH) : 1;
	localparam int BM_ADDR_W = (`CONV_BIAS_DEPTH > 1) ? $clog2(`CONV_BIAS_DEPTH) : 1;

	typedef logic signed [15:0] pixel_t;   // pixel or weight
	typedef logic signed [31:0] acc_t;     // accumulator, bias, result

	typedef logic [WM_ADDR_W-1:0] wm_addr_t;
	typedef logic [BM_ADDR_W-1:0] bm_addr_t;

	// index is row*K + column, row 0 and column 0 newest
	typedef pixel_t window_t [KERNEL_TAPS];

endpackage

//--- source/window_buffer.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module window_buffer
	import conv_pkg::*;
#(
	parameter int IFM_SIZE    = `CONV_IFM_SIZE,
	parameter int KERNEL_SIZE = `CONV_KERNEL_SIZE
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    fifo_enable,
	input  pixel_t  pixel_in,
	output window_t window
);

	// enough history to reach the oldest tap of the last window row
	localparam int CHAIN_LEN = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

	pixel_t chain [CHAIN_LEN];   // chain[0] is the newest pixel

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < CHAIN_LEN; i++) begin
				chain[i] <= '0;
			end
		end else if (fifo_enable) begin
			chain[0] <= pixel_in;
			for (int i = 1; i < CHAIN_LEN; i++) begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// rows of the window are one map row apart in the chain
	always_comb begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				window[r*KERNEL_SIZE + c] = chain[r*IFM_SIZE + c];
			end
		end
	end

endmodule

//--- source/coef_memory.sv
`timescale 1ns/1ps

module coef_memory #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 16
) (
	input  logic                                       clk,
	input  logic                                       write_enable,
	input  logic                                       read_enable,
	input  logic [$clog2((DEPTH > 1) ? DEPTH : 2)-1:0] address,
	input  payload_t                                   write_data,
	output payload_t                                   read_data
);

	payload_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (write_enable) begin
			mem[address] <= write_data;
		end
	end

	// output only moves on a read, otherwise the last word stays put
	always_ff @(posedge clk) begin
		if (read_enable) begin
			read_data <= mem[address];   // old word on a same-cycle write
		end
	end

endmodule

//--- source/conv_unit.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_unit
	import conv_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  window_t window,
	input  pixel_t  weight_in,
	input  logic    wm_fifo_enable,
	input  acc_t    bias,
	input  acc_t    partial_in,
	input  logic    conv_enable,
	input  logic    accu_enable,
	input  logic    relu_enable,
	output acc_t    result,
	output logic    result_valid
);

	pixel_t weights [KERNEL_TAPS];

	acc_t products [KERNEL_TAPS];   // stage 1
	acc_t addend;
	logic s1_valid;
	logic s1_relu;

	acc_t sum;   // stage 2, combinational

	// weight register, filled from the memory output one tap per enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < KERNEL_TAPS; i++) begin
				weights[i] <= '0;
			end
		end else if (wm_fifo_enable) begin
			weights[0] <= weight_in;
			for (int i = 1; i < KERNEL_TAPS; i++) begin
				weights[i] <= weights[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv_enable) begin
			for (int i = 0; i < KERNEL_TAPS; i++) begin
				products[i] <= acc_t'(window[i]) * acc_t'(weights[i]);
			end
			addend <= accu_enable ? partial_in : bias;   // chain in a partial sum
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_relu  <= 1'b0;
		end else begin
			s1_valid <= conv_enable;
			if (conv_enable) begin
				s1_relu <= relu_enable;
			end
		end
	end

	always_comb begin
		sum = addend;
		for (int i = 0; i < KERNEL_TAPS; i++) begin
			sum = sum + products[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result       <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= s1_valid;
			if (s1_valid) begin
				// relu clamps negative sums only
				if (s1_relu && sum[$bits(acc_t)-1]) begin
					result <= '0;
				end else begin
					result <= sum;
				end
			end
		end
	end

endmodule

//--- source/conv_datapath.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_datapath
	import conv_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst_n,

	// host write port
	input  acc_t                              host_data,
	input  wm_addr_t                          host_address,

	// input feature map stream
	input  pixel_t                            pixel_in,
	input  logic                              fifo_enable,

	// weight memories
	input  logic                              wm_addr_sel,
	input  wm_addr_t                          wm_address_read,
	input  logic                              wm_enable_read,
	input  logic [`CONV_NUM_UNITS-1:0]        wm_enable_write,
	input  logic                              wm_fifo_enable,

	// bias memories
	input  logic                              bm_addr_sel,
	input  bm_addr_t                          bm_address_read,
	input  logic                              bm_enable_read,
	input  logic [`CONV_NUM_UNITS-1:0]        bm_enable_write,

	input  logic                              conv_enable,
	input  logic                              accu_enable,
	input  logic                              relu_enable,
	input  acc_t [`CONV_NUM_UNITS-1:0]        partial_in,

	output acc_t [`CONV_NUM_UNITS-1:0]        result,
	output logic                              result_valid
);

	window_t  window;
	wm_addr_t wm_address;
	bm_addr_t bm_address;
	pixel_t   weight_wdata;

	logic [`CONV_NUM_UNITS-1:0] unit_valid;

	// select high reads for the datapath, low lets the host write
	assign wm_address = wm_addr_sel ? wm_address_read : host_address;
	assign bm_address = bm_addr_sel ? bm_address_read : host_address[$bits(bm_addr_t)-1:0];

	assign weight_wdata = host_data[$bits(pixel_t)-1:0];   // weights are 16 bit

	window_buffer #(
		.IFM_SIZE    (`CONV_IFM_SIZE),
		.KERNEL_SIZE (`CONV_KERNEL_SIZE)
	) u_window (
		.clk         (clk),
		.rst_n       (rst_n),
		.fifo_enable (fifo_enable),
		.pixel_in    (pixel_in),
		.window      (window)
	);

	for (genvar u = 0; u < `CONV_NUM_UNITS; u++) begin : g_unit
		pixel_t weight_word;
		acc_t   bias_word;

		coef_memory #(
			.payload_t (pixel_t),
			.DEPTH     (WM_DEPTH)
		) u_weight_mem (
			.clk          (clk),
			.write_enable (wm_enable_write[u]),
			.read_enable  (wm_enable_read),
			.address      (wm_address),
			.write_data   (weight_wdata),
			.read_data    (weight_word)
		);

		coef_memory #(
			.payload_t (acc_t),
			.DEPTH     (`CONV_BIAS_DEPTH)
		) u_bias_mem (
			.clk          (clk),
			.write_enable (bm_enable_write[u]),
			.read_enable  (bm_enable_read),
			.address      (bm_address),
			.write_data   (host_data),
			.read_data    (bias_word)
		);

		conv_unit u_conv (
			.clk            (clk),
			.rst_n          (rst_n),
			.window         (window),
			.weight_in      (weight_word),
			.wm_fifo_enable (wm_fifo_enable),
			.bias           (bias_word),
			.partial_in     (partial_in[u]),
			.conv_enable    (conv_enable),
			.accu_enable    (accu_enable),
			.relu_enable    (relu_enable),
			.result         (result[u]),
			.result_valid   (unit_valid[u])
		);
	end

	// units run in lockstep on shared enables
	assign result_valid = unit_valid[0];

endmodule

//--- tb/conv_checker.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_checker
	import conv_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       conv_enable,
	input  logic                       relu_enable,
	input  acc_t [`CONV_NUM_UNITS-1:0] result,
	input  logic                       result_valid,
	input  acc_t [`CONV_NUM_UNITS-1:0] expected_result,
	input  logic                       expected_valid
);

	int   fail_count = 0;
	logic conv_seen;   // set by the first conv_enable after reset

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			conv_seen <= 1'b0;
		end else if (conv_enable) begin
			conv_seen <= 1'b1;
		end
	end

	reset_state: assert property (@(posedge clk) !rst_n |-> (!result_valid && result == '0))
		else begin
			$error("Error at %0t: outputs not cleared in reset", $time);
			fail_count++;
		end

	idle_after_reset: assert property (@(posedge clk)
		rst_n && !conv_seen |-> (!result_valid && result == '0))
		else begin
			$error("Error at %0t: output moved before first conv", $time);
			fail_count++;
		end

	valid_model: assert property (@(posedge clk) rst_n |-> result_valid == expected_valid)
		else begin
			$error("Error at %0t: result_valid %0b expected %0b", $time,
				$sampled(result_valid), $sampled(expected_valid));
			fail_count++;
		end

	// fixed latency of two even for overlapping requests
	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		conv_enable |-> ##2 result_valid)
		else begin
			$error("Error at %0t: result_valid late or missing", $time);
			fail_count++;
		end

	valid_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!conv_enable |-> ##2 !result_valid)
		else begin
			$error("Error at %0t: result_valid without request", $time);
			fail_count++;
		end

	for (genvar u = 0; u < `CONV_NUM_UNITS; u++) begin : g_unit
		value_match: assert property (@(posedge clk) disable iff (!rst_n)
			result_valid |-> result[u] == expected_result[u])
			else begin
				$error("Error at %0t: unit %0d result %0d expected %0d", $time, u,
					$sampled(result[u]), $sampled(expected_result[u]));
				fail_count++;
			end

		relu_clamp: assert property (@(posedge clk) disable iff (!rst_n)
			conv_enable && relu_enable |-> ##2 !result[u][$bits(acc_t)-1])
			else begin
				$error("Error at %0t: unit %0d negative under relu", $time, u);
				fail_count++;
			end
	end

endmodule

//--- tb/conv_datapath_tb.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_datapath_tb
	import conv_pkg::*;
();

	localparam int K     = `CONV_KERNEL_SIZE;
	localparam int W     = `CONV_IFM_SIZE;
	localparam int NU    = `CONV_NUM_UNITS;
	localparam int CHAIN = (K - 1) * W + K;

	logic            clk;
	logic            rst_n;
	acc_t            host_data;
	wm_addr_t        host_address;
	pixel_t          pixel_in;
	logic            fifo_enable;
	logic            wm_addr_sel;
	wm_addr_t        wm_address_read;
	logic            wm_enable_read;
	logic [NU-1:0]   wm_enable_write;
	logic            wm_fifo_enable;
	logic            bm_addr_sel;
	bm_addr_t        bm_address_read;
	logic            bm_enable_read;
	logic [NU-1:0]   bm_enable_write;
	logic            conv_enable;
	logic            accu_enable;
	logic            relu_enable;
	acc_t [NU-1:0]   partial_in;
	acc_t [NU-1:0]   result;
	logic            result_valid;

	acc_t [NU-1:0]   next_expected;
	acc_t [NU-1:0]   staged_result;
	acc_t [NU-1:0]   expected_result;
	logic            staged_valid;
	logic            expected_valid;
	int              timeout_count;

	// reference state
	pixel_t hist [CHAIN];   // hist[0] newest pixel
	pixel_t wmem [NU][WM_DEPTH];
	acc_t   bmem [NU][`CONV_BIAS_DEPTH];
	pixel_t wreg [NU][KERNEL_TAPS];
	pixel_t wout [NU];
	acc_t   bout [NU];

	conv_datapath dut0 (.*);

	bind conv_datapath conv_checker chk0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.conv_enable     (conv_enable),
		.relu_enable     (relu_enable),
		.result          (result),
		.result_valid    (result_valid),
		.expected_result (conv_datapath_tb.expected_result),
		.expected_valid  (conv_datapath_tb.expected_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// results land two edges after the request
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			staged_valid    <= 1'b0;
			expected_valid  <= 1'b0;
			expected_result <= '0;
		end else begin
			staged_valid <= conv_enable;
			if (conv_enable) staged_result <= next_expected;
			expected_valid <= staged_valid;
			if (staged_valid) expected_result <= staged_result;
		end
	end

	function automatic int rand_small(int span);
		return int'($urandom_range(2 * span)) - span;
	endfunction

	task automatic idle_inputs();
		fifo_enable     <= 1'b0;
		wm_enable_read  <= 1'b0;
		wm_enable_write <= '0;
		wm_fifo_enable  <= 1'b0;
		bm_enable_read  <= 1'b0;
		bm_enable_write <= '0;
		conv_enable     <= 1'b0;
	endtask

	task automatic write_weight(int u, int addr, pixel_t w);
		@(posedge clk);
		idle_inputs();
		wm_addr_sel        <= 1'b0;
		host_address       <= wm_addr_t'(addr);
		host_data          <= {16'($urandom), w};   // upper half is dropped
		wm_address_read    <= wm_addr_t'($urandom_range(WM_DEPTH - 1));
		wm_enable_write[u] <= 1'b1;
		wmem[u][addr] = w;
	endtask

	task automatic write_bias(int u, int addr, acc_t b);
		@(posedge clk);
		idle_inputs();
		bm_addr_sel        <= 1'b0;
		host_address       <= wm_addr_t'(($urandom_range(2 ** (WM_ADDR_W - BM_ADDR_W) - 1)
			<< BM_ADDR_W) | addr);
		host_data          <= b;
		bm_address_read    <= bm_addr_t'($urandom_range(`CONV_BIAS_DEPTH - 1));
		bm_enable_write[u] <= 1'b1;
		bmem[u][addr] = b;
	endtask

	task automatic read_bias(int addr);
		@(posedge clk);
		idle_inputs();
		bm_addr_sel     <= 1'b1;
		bm_address_read <= bm_addr_t'(addr);
		bm_enable_read  <= 1'b1;
		for (int u = 0; u < NU; u++) bout[u] = bmem[u][addr];
	endtask

	// one read, then one shift per tap
	task automatic load_weights(int base);
		for (int k = 0; k < KERNEL_TAPS; k++) begin
			@(posedge clk);
			idle_inputs();
			wm_addr_sel     <= 1'b1;
			wm_address_read <= wm_addr_t'(base + k);
			host_address    <= wm_addr_t'($urandom_range(WM_DEPTH - 1));
			wm_enable_read  <= 1'b1;
			for (int u = 0; u < NU; u++) wout[u] = wmem[u][base + k];
			@(posedge clk);
			idle_inputs();
			wm_fifo_enable <= 1'b1;
			for (int u = 0; u < NU; u++) begin
				for (int i = KERNEL_TAPS - 1; i > 0; i--) wreg[u][i] = wreg[u][i-1];
				wreg[u][0] = wout[u];
			end
		end
	endtask

	task automatic drive_cycle(bit push, bit conv, bit accu, bit relu, int partial_offset);
		acc_t          parts [NU];
		acc_t [NU-1:0] calc;
		acc_t          sum;
		pixel_t        pix;
		@(posedge clk);
		idle_inputs();
		if (conv) begin
			for (int u = 0; u < NU; u++) begin
				parts[u] = rand_small(3000) + partial_offset;
				sum = accu ? parts[u] : bout[u];
				for (int r = 0; r < K; r++) begin
					for (int c = 0; c < K; c++) begin
						sum = sum + acc_t'(hist[r*W + c]) * acc_t'(wreg[u][r*K + c]);
					end
				end
				if (relu && sum < 0) sum = '0;
				calc[u] = sum;
				partial_in[u] <= parts[u];
			end
			conv_enable   <= 1'b1;
			accu_enable   <= accu;
			relu_enable   <= relu;
			next_expected <= calc;
		end else begin
			accu_enable <= 1'($urandom);   // ignored outside a request
			relu_enable <= 1'($urandom);
		end
		if (push) begin
			pix = pixel_t'(rand_small(30));
			pixel_in    <= pix;
			fifo_enable <= 1'b1;
			for (int i = CHAIN - 1; i > 0; i--) hist[i] = hist[i-1];
			hist[0] = pix;
		end
	endtask

	task automatic wait_for_valid();
		int n;
		n = 0;
		while (!result_valid && n < 10) begin
			@(posedge clk);
			idle_inputs();
			n++;
		end
		if (!result_valid) begin
			$display("timeout at %0t: no result_valid after a conv request", $time);
			timeout_count++;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		@(posedge clk);
		idle_inputs();
		while ((conv_enable || staged_valid || expected_valid || result_valid) && n < 10) begin
			@(posedge clk);
			idle_inputs();
			n++;
		end
		if (result_valid || expected_valid) begin
			$display("timeout at %0t: results kept coming after the requests stopped", $time);
			timeout_count++;
		end
	endtask

	initial begin
		rst_n           <= 1'b0;
		host_data       <= '0;
		host_address    <= '0;
		pixel_in        <= '0;
		wm_addr_sel     <= 1'b0;
		wm_address_read <= '0;
		bm_addr_sel     <= 1'b0;
		bm_address_read <= '0;
		accu_enable     <= 1'b0;
		relu_enable     <= 1'b0;
		partial_in      <= '0;
		next_expected   <= '0;
		idle_inputs();
		timeout_count = 0;
		for (int i = 0; i < CHAIN; i++) hist[i] = '0;
		for (int u = 0; u < NU; u++) begin
			for (int i = 0; i < KERNEL_TAPS; i++) wreg[u][i] = '0;
		end
		void'($urandom(32'hdf64));

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < 4; i++) drive_cycle(0, 0, 0, 0, 0);

		for (int u = 0; u < NU; u++) begin
			for (int a = 0; a < WM_DEPTH; a++) write_weight(u, a, pixel_t'(rand_small(20)));
			for (int a = 0; a < `CONV_BIAS_DEPTH; a++) write_bias(u, a, rand_small(800));
		end
		read_bias(0);
		load_weights(0);
		for (int i = 0; i < CHAIN; i++) drive_cycle(1, 0, 0, 0, 0);

		drive_cycle(0, 1, 0, 0, 0);   // lone request with bias
		wait_for_valid();
		drain();
		for (int i = 0; i < 24; i++) drive_cycle(1, 1, 0, 0, 0);
		drain();

		for (int i = 0; i < 12; i++) drive_cycle(1, 1, 1, 0, 0);   // chained partial sums
		drain();

		for (int i = 0; i < 24; i++) drive_cycle(1, 1, i % 2, 1, 0);
		drain();
		drive_cycle(0, 1, 1, 1, -100000);   // clamps to zero
		wait_for_valid();
		drain();
		drive_cycle(0, 1, 1, 1, 100000);
		wait_for_valid();
		drain();

		// second channel, unit 1 rewritten, other bias word
		for (int a = KERNEL_TAPS; a < WM_DEPTH; a++) write_weight(1, a, pixel_t'(rand_small(20)));
		write_bias(2, 3, rand_small(5000));
		read_bias(3);
		load_weights(KERNEL_TAPS);
		for (int i = 0; i < 16; i++) drive_cycle(1, 1, 1'($urandom), 1'($urandom), 0);
		drain();
		for (int i = 0; i < 12; i++) drive_cycle(1, i % 3 == 0, 0, 1, 0);
		drain();

		$display("closing: %0d assertion failures, %0d timeouts",
			dut0.chk0.fail_count, timeout_count);
		if (dut0.chk0.fail_count == 0 && timeout_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+source
source/conv_pkg.sv
source/window_buffer.sv
source/coef_memory.sv
source/conv_unit.sv
source/conv_datapath.sv
tb/conv_checker.sv
tb/conv_datapath_tb.sv

//--- Bender.yml
package:
  name: conv_datapath

sources:
  - include_dirs:
      - source
    files:
      - source/conv_pkg.sv
      - source/window_buffer.sv
      - source/coef_memory.sv
      - source/conv_unit.sv
      - source/conv_datapath.sv

  - target: test
    include_dirs:
      - source
    files:
      - tb/conv_checker.sv
      - tb/conv_datapath_tb.sv
